// File: run_sim.sh
#!/bin/sh
# Build the PET bus core testbench with Verilator, run it, then scan the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module pet_bus_tb \
    -o pet_bus_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/pet_bus_sim > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation ended without passing"; exit 1; }
echo "Simulation passed"

// File: source/address_decoder.sv
// Combinational decode of the PET memory map for the CPU side
// RAM answers everywhere except the I/O page; ROM space is flagged read-only
`timescale 1ns/1ns

module address_decoder (
    input  pet_pkg::cpu_addr_t cpu_addr_i,
    output logic               ram_en_o,
    output logic               pia1_en_o,
    output logic               pia2_en_o,
    output logic               via_en_o,
    output logic               io_en_o,
    output logic               readonly_o,
    output pet_pkg::addr_t     ram_addr_o
);
    import pet_pkg::*;

    logic io_page;                                      // $E800-$E8FF
    logic vram_hit;                                     // $8000-$8FFF

    assign io_page  = cpu_addr_i >= IO_BASE && cpu_addr_i <= IO_TOP;
    assign vram_hit = cpu_addr_i >= VRAM_BASE && cpu_addr_i <= VRAM_TOP;

    // Each device owns a 16 byte window, compare the upper 12 bits only
    assign pia1_en_o = cpu_addr_i[15:4] == PIA1_BASE[15:4];
    assign pia2_en_o = cpu_addr_i[15:4] == PIA2_BASE[15:4];
    assign via_en_o  = cpu_addr_i[15:4] == VIA_BASE[15:4];

    // Rest of the I/O page goes to the expansion I/O strobe
    assign io_en_o = io_page && !pia1_en_o && !pia2_en_o && !via_en_o;

    assign ram_en_o = !io_page;

    // Everything from $9000 up is ROM image, the I/O page is excluded
    assign readonly_o = cpu_addr_i >= ROM_BASE && !io_page;

    // 1 KB of video RAM repeats four times across the 4 KB window
    always_comb begin
        ram_addr_o = {1'b0, cpu_addr_i};                // CPU only sees the lower 64 KB
        if (vram_hit) begin
            ram_addr_o[11:10] = 2'b00;
        end
    end

endmodule

// File: source/cycle_timer.sv
// Divides the 16 MHz clock into 1 MHz CPU cycles of 16 phases
// Phases 0-7 belong to the host, 8-15 to the CPU; phase is 0 after reset
`timescale 1ns/1ns

module cycle_timer (
    input  logic            clk_16_i,
    input  logic            rst_n_i,
    output pet_pkg::phase_t phase_o,
    output logic            host_slot_o,
    output logic            cpu_slot_o,
    output logic            cpu_write_phase_o,
    output logic            clk_cpu_o
);
    import pet_pkg::*;

    phase_t phase_next;

    assign phase_next = phase_o + 4'd1;                 // Wraps from 15 back to 0

    // Flags are computed from the next phase so they line up with phase_o
    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_o           <= PHASE_HOST_START;
            host_slot_o       <= 1'b1;                  // Phase 0 is host time
            cpu_slot_o        <= 1'b0;
            cpu_write_phase_o <= 1'b0;
        end else begin
            phase_o           <= phase_next;
            host_slot_o       <= phase_next < PHASE_CPU_START;
            cpu_slot_o        <= phase_next >= PHASE_CPU_START;
            cpu_write_phase_o <= phase_next == PHASE_CPU_WRITE;
        end
    end

    // Straight from a flop, so the CPU clock has no decode glitches
    assign clk_cpu_o = cpu_slot_o;

    // The two slots share the RAM port and must never overlap
    a_slots_exclusive: assert property (
        @(posedge clk_16_i) disable iff (!rst_n_i)
        !(host_slot_o && cpu_slot_o)
    ) else $error("host and CPU slot both active at phase %0d", phase_o);

endmodule

// File: source/host_arbiter.sv
// Places host requests into the host slot, one request in flight at a time
// The host must hold valid, address and rw until it sees the ready pulse
// Only host writes to $1E800-$1E809 go to the keyboard; reads there hit RAM
`timescale 1ns/1ns

module host_arbiter (
    input  logic            clk_16_i,
    input  logic            rst_n_i,
    input  logic            host_valid_i,
    input  logic            host_rw_n_i,
    input  pet_pkg::addr_t  host_addr_i,
    input  pet_pkg::phase_t phase_i,
    output logic            grant_o,
    output logic            grant_kbd_o,
    output logic            host_ready_o
);
    import pet_pkg::*;

    arb_state_t state_q;
    arb_state_t state_d;
    logic       kbd_wr;                                 // Request targets a keyboard row

    assign kbd_wr = !host_rw_n_i
                    && host_addr_i >= KBD_BASE
                    && host_addr_i < KBD_BASE + addr_t'(KBD_ROWS);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (host_valid_i) begin
                    // Early enough to grant on the next phase and finish in the slot
                    state_d = (phase_i <= PHASE_REQ_LAST) ? ARB_ACCESS : ARB_WAIT_SLOT;
                end
            end
            ARB_WAIT_SLOT: begin
                // Phase 15 rolls into phase 0, the start of the next host slot
                if (phase_i == PHASE_CPU_WRITE || phase_i <= PHASE_REQ_LAST) begin
                    state_d = ARB_ACCESS;
                end
            end
            ARB_ACCESS: state_d = ARB_DONE;             // RAM read data lands next cycle
            ARB_DONE:   state_d = ARB_IDLE;             // Host may present a new request
            default:    state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign grant_o      = (state_q == ARB_ACCESS) && !kbd_wr;
    assign grant_kbd_o  = (state_q == ARB_ACCESS) && kbd_wr;
    assign host_ready_o = state_q == ARB_DONE;

    // Grant and its ready cycle both stay inside the host half of the timer cycle
    a_grant_phase: assert property (
        @(posedge clk_16_i) disable iff (!rst_n_i)
        (grant_o || grant_kbd_o) |-> phase_i <= PHASE_GRANT_LAST
    ) else $error("host grant at phase %0d in %s", phase_i, state_q.name());

    // One pulse per request, never back to back
    a_ready_single: assert property (
        @(posedge clk_16_i) disable iff (!rst_n_i)
        host_ready_o |=> !host_ready_o
    ) else $error("host_ready_o high on two cycles in a row");

endmodule

// File: source/keyboard_matrix.sv
// Keyboard rows written by the host, read by the CPU through PIA1 port B
// A released key reads as 1; rows 10-15 do not exist and read $FF
`timescale 1ns/1ns

module keyboard_matrix (
    input  logic               clk_16_i,
    input  logic               rst_n_i,
    input  logic               host_wr_i,
    input  pet_pkg::kbd_row_t  host_row_i,
    input  pet_pkg::data_t     host_data_i,
    input  pet_pkg::cpu_addr_t cpu_addr_i,
    input  pet_pkg::data_t     cpu_data_i,
    input  logic               cpu_rw_n_i,
    input  logic               cpu_write_phase_i,
    input  logic               cpu_slot_i,
    output logic               kbd_hit_o,
    output pet_pkg::data_t     kbd_data_o
);
    import pet_pkg::*;

    data_t    rows [KBD_ROWS];                          // One byte per matrix row
    kbd_row_t row_sel;                                  // Last row written to port A
    logic     sel_wr;                                   // CPU write to port A this cycle

    assign sel_wr = cpu_slot_i && cpu_write_phase_i && !cpu_rw_n_i
                    && cpu_addr_i == PIA1_PORTA;

    // Host side updates rows at its grant
    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < KBD_ROWS; i++) begin
                rows[i] <= 8'hFF;                       // No key down
            end
        end else if (host_wr_i && host_row_i < KBD_ROWS) begin
            rows[host_row_i] <= host_data_i;
        end
    end

    // The PET kernal scans by writing the row number to port A
    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            row_sel <= '0;
        end else if (sel_wr) begin
            row_sel <= cpu_data_i[3:0];                 // Upper bits drive other PIA1 lines
        end
    end

    // CPU read of port B is answered here instead of by the PIA
    assign kbd_hit_o = cpu_slot_i && cpu_rw_n_i && cpu_addr_i == PIA1_PORTB;

    assign kbd_data_o = (row_sel < KBD_ROWS) ? rows[row_sel] : 8'hFF;

endmodule

// File: source/mem_access_if.sv
// One granted RAM access, driven by whichever side owns the current slot
// rdata follows a read one clock after en is sampled high with we low
`timescale 1ns/1ns

interface mem_access_if;
    import pet_pkg::*;

    logic  en;                  // Access this cycle
    logic  we;                  // Write when high together with en
    addr_t addr;                // Already mirrored for CPU accesses
    data_t wdata;
    data_t rdata;               // Registered read data from the array

    modport ram (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

    modport owner (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

endinterface

// File: source/pet_bus_top.sv
// PET bus core: host port in phases 0-7, 6502 bus in phases 8-15
// Separate in/out data ports stand in for the tristate system bus
// CPU address must stay stable through the CPU slot for reads to settle
`timescale 1ns/1ns

module pet_bus_top (
    input  logic               clk_16_i,
    input  logic               rst_n_i,
    input  logic               host_valid_i,
    input  logic               host_rw_n_i,
    input  pet_pkg::addr_t     host_addr_i,
    input  pet_pkg::data_t     host_wdata_i,
    output logic               host_ready_o,
    output pet_pkg::data_t     host_rdata_o,
    input  pet_pkg::cpu_addr_t cpu_addr_i,
    input  pet_pkg::data_t     cpu_data_i,
    input  logic               cpu_rw_n_i,
    output pet_pkg::data_t     cpu_data_o,
    output logic               clk_cpu_o,
    output logic               cpu_en_o,
    output logic               ram_ce_no,
    output logic               pia1_cs_no,
    output logic               pia2_cs_no,
    output logic               via_cs_no,
    output logic               io_oe_no
);
    import pet_pkg::*;

    phase_t phase;
    logic   host_slot;
    logic   cpu_slot;
    logic   cpu_write_phase;
    logic   grant;                                      // Host RAM access this cycle
    logic   grant_kbd;                                  // Host keyboard row write this cycle
    logic   ram_en;
    logic   pia1_en;
    logic   pia2_en;
    logic   via_en;
    logic   io_en;
    logic   readonly;
    addr_t  cpu_ram_addr;                               // CPU address after VRAM mirroring
    logic   kbd_hit;
    data_t  kbd_data;
    data_t  host_rdata_q;                               // Last host read, held after ready

    mem_access_if ram_bus ();

    cycle_timer u_timer (
        .clk_16_i(clk_16_i), .rst_n_i(rst_n_i), .phase_o(phase),
        .host_slot_o(host_slot), .cpu_slot_o(cpu_slot),
        .cpu_write_phase_o(cpu_write_phase), .clk_cpu_o(clk_cpu_o)
    );

    host_arbiter u_arbiter (
        .clk_16_i(clk_16_i), .rst_n_i(rst_n_i), .host_valid_i(host_valid_i),
        .host_rw_n_i(host_rw_n_i), .host_addr_i(host_addr_i), .phase_i(phase),
        .grant_o(grant), .grant_kbd_o(grant_kbd), .host_ready_o(host_ready_o)
    );

    address_decoder u_decoder (
        .cpu_addr_i(cpu_addr_i), .ram_en_o(ram_en), .pia1_en_o(pia1_en),
        .pia2_en_o(pia2_en), .via_en_o(via_en), .io_en_o(io_en),
        .readonly_o(readonly), .ram_addr_o(cpu_ram_addr)
    );

    keyboard_matrix u_keyboard (
        .clk_16_i(clk_16_i), .rst_n_i(rst_n_i), .host_wr_i(grant_kbd),
        .host_row_i(host_addr_i[3:0]),                  // KBD_BASE is nibble aligned
        .host_data_i(host_wdata_i), .cpu_addr_i(cpu_addr_i), .cpu_data_i(cpu_data_i),
        .cpu_rw_n_i(cpu_rw_n_i), .cpu_write_phase_i(cpu_write_phase),
        .cpu_slot_i(cpu_slot), .kbd_hit_o(kbd_hit), .kbd_data_o(kbd_data)
    );

    system_ram u_ram (.clk_16_i(clk_16_i), .bus(ram_bus));

    // Slot owner drives the RAM port
    always_comb begin
        ram_bus.en    = 1'b0;
        ram_bus.we    = 1'b0;
        ram_bus.addr  = host_addr_i;
        ram_bus.wdata = host_wdata_i;
        if (host_slot) begin
            ram_bus.en = grant;
            ram_bus.we = grant && !host_rw_n_i;
        end else if (cpu_slot) begin
            ram_bus.en    = ram_en;                     // Reads refresh every CPU phase
            ram_bus.we    = ram_en && cpu_write_phase && !cpu_rw_n_i && !readonly;
            ram_bus.addr  = cpu_ram_addr;
            ram_bus.wdata = cpu_data_i;
        end
    end

    assign cpu_en_o = cpu_slot;                         // 6502 bus enable follows the slot

    // Selects are active low and only in the CPU slot
    assign ram_ce_no  = !(ram_en && cpu_en_o);
    assign pia1_cs_no = !(pia1_en && !kbd_hit && cpu_en_o); // Port B read is intercepted
    assign pia2_cs_no = !(pia2_en && cpu_en_o);
    assign via_cs_no  = !(via_en && cpu_en_o);
    assign io_oe_no   = !(io_en && cpu_en_o);

    assign cpu_data_o = kbd_hit ? kbd_data : ram_bus.rdata;

    // Read data is live in the ready cycle and held after it
    always_ff @(posedge clk_16_i) begin
        if (host_ready_o) begin
            host_rdata_q <= ram_bus.rdata;
        end
    end

    assign host_rdata_o = host_ready_o ? ram_bus.rdata : host_rdata_q;

endmodule

// File: source/pet_pkg.sv
// Shared widths, PET memory map and cycle phase numbers for the bus core
// The map assumes a 40 column PET with 1 KB of video RAM mirrored four times
package pet_pkg;

    typedef logic [16:0] addr_t;        // Host address, bit 16 reaches the upper 64 KB
    typedef logic [15:0] cpu_addr_t;    // 6502 address
    typedef logic [7:0]  data_t;        // One bus byte
    typedef logic [3:0]  phase_t;       // 16 phases per 1 MHz CPU cycle
    typedef logic [3:0]  kbd_row_t;     // Keyboard row index, rows 10-15 unused

    typedef enum logic [1:0] {
        ARB_IDLE,                       // No host request pending
        ARB_WAIT_SLOT,                  // Request seen too late in the host slot
        ARB_ACCESS,                     // One cycle grant to RAM or keyboard
        ARB_DONE                        // Ready pulse, read data on the bus
    } arb_state_t;

    localparam int RAM_DEPTH = 1 << 17; // 128 KB behind the 17-bit address

    // Phase numbers inside one CPU cycle
    localparam phase_t PHASE_HOST_START = 4'd0;
    localparam phase_t PHASE_REQ_LAST   = 4'd5;  // Latest phase to go straight to a grant
    localparam phase_t PHASE_GRANT_LAST = 4'd6;  // Grant must leave room for the ready cycle
    localparam phase_t PHASE_CPU_START  = 4'd8;  // clk_cpu_o high from here through 15
    localparam phase_t PHASE_CPU_WRITE  = 4'd15; // CPU write committed on this phase

    // Keyboard rows as seen from the host
    localparam addr_t KBD_BASE = 17'h1E800;
    localparam int    KBD_ROWS = 10;

    // CPU memory map
    localparam cpu_addr_t VRAM_BASE  = 16'h8000;
    localparam cpu_addr_t VRAM_TOP   = 16'h8FFF;
    localparam cpu_addr_t ROM_BASE   = 16'h9000;
    localparam cpu_addr_t IO_BASE    = 16'hE800;
    localparam cpu_addr_t IO_TOP     = 16'hE8FF;
    localparam cpu_addr_t PIA1_BASE  = 16'hE810; // Each device decodes 16 bytes
    localparam cpu_addr_t PIA2_BASE  = 16'hE820;
    localparam cpu_addr_t VIA_BASE   = 16'hE840;
    localparam cpu_addr_t PIA1_PORTA = 16'hE810; // Keyboard row select
    localparam cpu_addr_t PIA1_PORTB = 16'hE812; // Keyboard column read

endpackage

// File: source/system_ram.sv
// 128 K x 8 synchronous RAM with a single port and registered read data
// rdata keeps its value until the next read, writes do not update it
`timescale 1ns/1ns

module system_ram (
    input logic       clk_16_i,
    mem_access_if.ram bus
);
    import pet_pkg::*;

    data_t mem [RAM_DEPTH];                             // Whole 17-bit space, no holes

    always_ff @(posedge clk_16_i) begin
        if (bus.en) begin
            if (bus.we) begin
                mem[bus.addr] <= bus.wdata;
            end else begin
                bus.rdata <= mem[bus.addr];             // Seen by the owner next cycle
            end
        end
    end

    // Slot mux must hand a clean address to the array in both slots
    a_addr_known: assert property (
        @(posedge clk_16_i)
        bus.en |-> !$isunknown(bus.addr)
    ) else $error("RAM access with unknown address %h", bus.addr);

endmodule

// File: verif/pet_bus_tb.sv
// Random host and CPU traffic against the PET bus core, fixed seed 83
// Host and CPU accesses run one after the other, never in the same CPU cycle
`timescale 1ns/1ns

module pet_bus_tb;
    import pet_pkg::*;

    localparam int N_HOST = 200;                        // Host writes, then as many reads
    localparam int N_CPU  = 40;                         // Preload, CPU read, CPU write, read-back
    localparam int N_VRAM = 20;
    localparam int N_DEV  = 40;
    localparam int N_KBD  = 30;                         // Row select write plus port B read
    localparam int N_OPS  = 2 * N_HOST + 4 * N_CPU + 2 * N_VRAM + N_DEV + KBD_ROWS + 2 * N_KBD;
    localparam int CYCLE_LIMIT = 20 * 16 * N_OPS;       // Worst-case latency per operation

    logic      clk_16;
    logic      rst_n;
    logic      host_valid;
    logic      host_rw_n;
    addr_t     host_addr;
    data_t     host_wdata;
    logic      host_ready;
    data_t     host_rdata;
    cpu_addr_t cpu_addr;
    data_t     cpu_data_in;                             // CPU to DUT
    logic      cpu_rw_n;
    data_t     cpu_data_out;                            // DUT to CPU
    logic      clk_cpu;
    logic      cpu_en;
    logic      ram_ce_n;
    logic      pia1_cs_n;
    logic      pia2_cs_n;
    logic      via_cs_n;
    logic      io_oe_n;

    data_t     model_mem [RAM_DEPTH];                   // Reference RAM
    data_t     model_rows [KBD_ROWS];                   // Reference keyboard matrix
    kbd_row_t  model_sel = '0;                          // Last row written to port A
    phase_t    phase;                                   // DUT phase, valid after each edge
    addr_t     addrs [N_HOST];
    integer    seed = 83;
    int        cycles = 0;
    int        errors = 0;

    pet_bus_top DUT (
        .clk_16_i(clk_16), .rst_n_i(rst_n), .host_valid_i(host_valid),
        .host_rw_n_i(host_rw_n), .host_addr_i(host_addr), .host_wdata_i(host_wdata),
        .host_ready_o(host_ready), .host_rdata_o(host_rdata), .cpu_addr_i(cpu_addr),
        .cpu_data_i(cpu_data_in), .cpu_rw_n_i(cpu_rw_n), .cpu_data_o(cpu_data_out),
        .clk_cpu_o(clk_cpu), .cpu_en_o(cpu_en), .ram_ce_no(ram_ce_n), .pia1_cs_no(pia1_cs_n),
        .pia2_cs_no(pia2_cs_n), .via_cs_no(via_cs_n), .io_oe_no(io_oe_n)
    );

    initial begin
        clk_16 = 1'b0;
        forever #5 clk_16 = ~clk_16;
    end

    task automatic fail_stop();
        errors++;
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    // Phase tracking and run length limit
    always @(posedge clk_16) begin
        if (!rst_n) begin
            phase <= '0;
        end else begin
            phase  <= phase + 4'd1;
            cycles <= cycles + 1;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Timeout: the run went past its limit of %0d cycles", CYCLE_LIMIT);
                fail_stop();
            end
        end
    end

    // CPU clock 8 low, 8 high; no select outside the CPU slot
    always @(negedge clk_16) begin
        if (rst_n) begin
            check_val("clk_cpu_o", clk_cpu, phase >= PHASE_CPU_START);
            check_val("cpu_en_o", cpu_en, phase >= PHASE_CPU_START);
            if (phase < PHASE_CPU_START) begin
                check_val("host slot selects", {ram_ce_n, pia1_cs_n, pia2_cs_n, via_cs_n,
                          io_oe_n}, 5'h1F);
            end
        end
    end

    // Video RAM repeats every 1 KB inside $8000-$8FFF
    function automatic addr_t cpu_to_ram_addr(input cpu_addr_t a);
        addr_t m;
        m = {1'b0, a};
        if (a >= VRAM_BASE && a <= VRAM_TOP) begin
            m[11:10] = 2'b00;
        end
        return m;
    endfunction

    task automatic host_access(input logic rw_n, input addr_t addr, input data_t wdata,
                               output data_t rdata);
        int waited;
        waited = 0;
        @(posedge clk_16);
        #1;
        host_valid = 1'b1;
        host_rw_n  = rw_n;
        host_addr  = addr;
        host_wdata = wdata;
        do begin
            @(negedge clk_16);
            waited++;
            assert (waited <= 12) else begin
                $display("Host request to %h saw no ready within 12 cycles", addr);
                fail_stop();
            end
        end while (!host_ready);
        rdata = host_rdata;
        @(posedge clk_16);
        #1;
        host_valid = 1'b0;
        @(negedge clk_16);
        check_val("ready pulse length", host_ready, 1'b0);
        if (!rw_n && addr >= KBD_BASE && addr < KBD_BASE + KBD_ROWS) begin
            model_rows[addr - KBD_BASE] = wdata;
        end else if (!rw_n) begin
            model_mem[addr] = wdata;
        end
    endtask

    // One CPU bus cycle; address set in phase 7 and held through phase 15
    task automatic cpu_cycle(input logic rw_n, input cpu_addr_t addr, input data_t wdata);
        logic [4:0] exp_cs;                             // ram, pia1, pia2, via, io
        logic       io_page;
        io_page = addr >= IO_BASE && addr <= IO_TOP;
        exp_cs  = 5'h1F;
        if (!io_page) begin
            exp_cs[4] = 1'b0;
        end else if (addr[15:4] == PIA1_BASE[15:4]) begin
            exp_cs[3] = rw_n && addr == PIA1_PORTB;     // Keyboard read bypasses the PIA
        end else if (addr[15:4] == PIA2_BASE[15:4]) begin
            exp_cs[2] = 1'b0;
        end else if (addr[15:4] == VIA_BASE[15:4]) begin
            exp_cs[1] = 1'b0;
        end else begin
            exp_cs[0] = 1'b0;
        end
        do begin
            @(posedge clk_16);
            #1;
        end while (phase != 4'd7);
        cpu_addr    = addr;
        cpu_rw_n    = rw_n;
        cpu_data_in = wdata;
        do begin
            @(negedge clk_16);
            if (phase >= PHASE_CPU_START) begin
                check_val("CPU slot selects", {ram_ce_n, pia1_cs_n, pia2_cs_n, via_cs_n,
                          io_oe_n}, exp_cs);
            end
            if (phase == 4'd12 && rw_n && addr == PIA1_PORTB) begin
                check_val("keyboard row", cpu_data_out,
                          model_sel < KBD_ROWS ? model_rows[model_sel] : 8'hFF);
            end else if (phase == 4'd12 && rw_n && !io_page) begin
                check_val("CPU read", cpu_data_out, model_mem[cpu_to_ram_addr(addr)]);
            end
        end while (phase != PHASE_CPU_WRITE);
        @(posedge clk_16);                              // Write commits on this edge
        #1;
        cpu_rw_n = 1'b1;
        if (!rw_n && addr == PIA1_PORTA) begin
            model_sel = wdata[3:0];
        end
        if (!rw_n && !io_page && addr < ROM_BASE) begin
            model_mem[cpu_to_ram_addr(addr)] = wdata;
        end
    endtask

    initial begin
        data_t     rd;
        data_t     b;
        cpu_addr_t a;
        rst_n       = 1'b0;
        host_valid  = 1'b0;
        host_rw_n   = 1'b1;
        host_addr   = '0;
        host_wdata  = '0;
        cpu_addr    = '0;
        cpu_data_in = '0;
        cpu_rw_n    = 1'b1;
        for (int r = 0; r < KBD_ROWS; r++) begin
            model_rows[r] = 8'hFF;                      // No key down after reset
        end
        repeat (4) @(posedge clk_16);
        #1;
        rst_n = 1'b1;
        @(negedge clk_16);
        check_val("outputs after reset", {host_ready, cpu_en, clk_cpu, ram_ce_n, pia1_cs_n,
                  pia2_cs_n, via_cs_n, io_oe_n}, 8'b0001_1111);

        for (int i = 0; i < N_HOST; i++) begin
            do begin
                addrs[i] = addr_t'($random(seed));
            end while (addrs[i] >= KBD_BASE && addrs[i] < KBD_BASE + KBD_ROWS);
            host_access(1'b0, addrs[i], data_t'($random(seed)), rd);
        end
        for (int i = 0; i < N_HOST; i++) begin
            host_access(1'b1, addrs[i], 8'h00, rd);
            check_val("host read", rd, model_mem[addrs[i]]);
        end

        for (int i = 0; i < N_CPU; i++) begin
            do begin
                a = cpu_addr_t'($random(seed));
            end while (a >= IO_BASE && a <= IO_TOP);
            host_access(1'b0, cpu_to_ram_addr(a), data_t'($random(seed)), rd);
            cpu_cycle(1'b1, a, 8'h00);
            cpu_cycle(1'b0, a, data_t'($random(seed)));  // Dropped from $9000 up
            host_access(1'b1, cpu_to_ram_addr(a), 8'h00, rd);
            check_val("read-back after CPU write", rd, model_mem[cpu_to_ram_addr(a)]);
        end

        for (int i = 0; i < N_VRAM; i++) begin
            a = VRAM_BASE | (cpu_addr_t'($random(seed)) & 16'h0FFF);
            b = data_t'($random(seed));
            cpu_cycle(1'b0, a, b);
            host_access(1'b1, {1'b0, a[15:12], 2'b00, a[9:0]}, 8'h00, rd);
            check_val("VRAM mirror", rd, b);
        end

        for (int i = 0; i < N_DEV; i++) begin
            cpu_cycle(1'b1, IO_BASE | (cpu_addr_t'($random(seed)) & 16'h00FF), 8'h00);
        end

        for (int r = 0; r < KBD_ROWS; r++) begin
            host_access(1'b0, KBD_BASE + addr_t'(r), data_t'($random(seed)), rd);
        end
        for (int i = 0; i < N_KBD; i++) begin
            cpu_cycle(1'b0, PIA1_PORTA, data_t'($random(seed)));  // Low nibble picks a row
            cpu_cycle(1'b1, PIA1_PORTB, 8'h00);
        end

        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
source/pet_pkg.sv
source/mem_access_if.sv
source/cycle_timer.sv
source/host_arbiter.sv
source/address_decoder.sv
source/keyboard_matrix.sv
source/system_ram.sv
source/pet_bus_top.sv
verif/pet_bus_tb.sv
